// ==== hdl/acs_array.sv ====
`timescale 1ns/1ps

`include "vit_config.svh"

module acs_array import vit_trellis_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  symbol_t  in_symbol,
    input  logic     accept,
    input  logic     acs_en,
    surv_if.writer   surv,
    output state_t   best_state
);

    symbol_t   sym_q;
    metric_t   pm_q [`VIT_NUM_STATES];
    metric_t   min_q;
    metric_t   pm_d [`VIT_NUM_STATES];
    decision_t dec_d;
    state_t    best_d;
    metric_t   best_m;

    // hamming distance between the symbol and the code word of one
    // transition, win is {predecessor state, input bit}
    function automatic bmetric_t branch_metric(input symbol_t sym, input logic [`VIT_K-1:0] win);
        symbol_t code;
        code[0] = ^(win & `VIT_G0);
        code[1] = ^(win & `VIT_G1);
        branch_metric = {1'b0, code[0] ^ sym[0]} + {1'b0, code[1] ^ sym[1]};
    endfunction

    // symbol held for the ACS cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            sym_q <= in_symbol;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // add compare select, all states at once
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [`VIT_METRIC_W:0] sum0;
        logic [`VIT_METRIC_W:0] sum1;
        logic [`VIT_METRIC_W:0] norm;
        state_t ns;
        state_t p0;
        state_t p1;
        for (int s = 0; s < `VIT_NUM_STATES; s++) begin
            ns = state_t'(s);
            // predecessors differ only in the bit shifted out
            p0 = {1'b0, ns[`VIT_K-2:1]};
            p1 = {1'b1, ns[`VIT_K-2:1]};
            sum0 = {1'b0, pm_q[p0]} + branch_metric(sym_q, {1'b0, ns});
            sum1 = {1'b0, pm_q[p1]} + branch_metric(sym_q, {1'b1, ns});
            // ties keep the lower predecessor
            dec_d[s] = (sum1 < sum0);
            norm = (dec_d[s] ? sum1 : sum0) - {1'b0, min_q};
            // unreached states sit at the top until a real path arrives
            pm_d[s] = norm[`VIT_METRIC_W] ? '1 : norm[`VIT_METRIC_W-1:0];
        end
    end

    // best state over the new metrics, lowest index on a tie
    always_comb begin
        best_d = '0;
        best_m = pm_d[0];
        for (int s = 1; s < `VIT_NUM_STATES; s++) begin
            if (pm_d[s] < best_m) begin
                best_d = state_t'(s);
                best_m = pm_d[s];
            end
        end
    end

    // metric registers, encoder known to start in state 0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `VIT_NUM_STATES; s++) begin
                pm_q[s] <= (s == 0) ? '0 : '1;
            end
            min_q <= '0;
        end else if (acs_en) begin
            pm_q  <= pm_d;
            min_q <= best_m;
        end
    end

    assign surv.wr_en   = acs_en;
    assign surv.wr_data = dec_d;
    assign best_state   = best_d;

endmodule

// ==== hdl/survivor_mem.sv ====
`timescale 1ns/1ps

`include "vit_config.svh"

module survivor_mem import vit_trellis_pkg::*; (
    input logic clk,
    input logic reset,
    surv_if.mem surv
);

    decision_t mem [`VIT_SURV_DEPTH];
    surv_ptr_t wr_ptr;
    surv_ptr_t wr_addr;

    // next word goes one past the newest, wrapping round the buffer
    assign wr_addr = wr_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (surv.wr_en) begin
            mem[wr_addr] <= surv.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (surv.wr_en) begin
            wr_ptr <= wr_addr;
        end
    end

    assign surv.wr_ptr = wr_ptr;

    // asynchronous read for the traceback walk
    assign surv.rd_data = mem[surv.rd_addr];

endmodule

// ==== hdl/traceback_unit.sv ====
`timescale 1ns/1ps

`include "vit_config.svh"

module traceback_unit import vit_trellis_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   trace_start,
    input  logic   trace_step,
    input  state_t best_state,
    surv_if.reader surv,
    output logic   out_bit
);

    state_t    cur_state;
    surv_ptr_t rd_addr;
    logic      last_bit;
    logic      upper;
    state_t    pred_state;

    ////////////////////////////////////////////////////////////////////////
    // backward walk through the survivor words
    ////////////////////////////////////////////////////////////////////////

    // decision of the current state picks which predecessor survived
    assign upper      = surv.rd_data[cur_state];
    assign pred_state = {upper, cur_state[`VIT_K-2:1]};

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_state <= '0;
            rd_addr   <= '0;
            last_bit  <= 1'b0;
        end else if (trace_start) begin
            cur_state <= best_state;
            // the word of this symbol is written on the same edge,
            // one past the current newest entry
            rd_addr   <= surv.wr_ptr + 1'b1;
        end else if (trace_step) begin
            cur_state <= pred_state;
            rd_addr   <= rd_addr - 1'b1;
            // input bit of the symbol being stepped over
            last_bit  <= cur_state[0];
        end
    end

    assign surv.rd_addr = rd_addr;

    // holds after the final step until the next traceback
    assign out_bit = last_bit;

endmodule

// ==== hdl/vit_config.svh ====
`ifndef VIT_CONFIG_SVH
`define VIT_CONFIG_SVH

////////////////////////////////////////////////////////////////////////
// convolutional code, rate 1/2
////////////////////////////////////////////////////////////////////////

// constraint length and trellis size
`define VIT_K 5
`define VIT_NUM_STATES 16

// generator taps, 23 and 35 octal
// bit 0 of a tap mask lines up with the newest input bit of the
// encoder window {state, input}; symbol bit 0 comes from G0, bit 1 from G1
`define VIT_G0 5'o23
`define VIT_G1 5'o35

////////////////////////////////////////////////////////////////////////
// decoder sizing
////////////////////////////////////////////////////////////////////////

// path metric width, saturating at the all-ones value
`define VIT_METRIC_W 6

// symbols walked back per decoded bit
`define VIT_TB_DEPTH 20

// survivor storage
`define VIT_SURV_DEPTH 32
`define VIT_PTR_W 5

`endif

// ==== hdl/vit_control.sv ====
`timescale 1ns/1ps

module vit_control import vit_ctrl_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  logic out_ready,
    output logic out_valid,
    output logic acs_en,
    step_if.ctrl step
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (in_valid) begin
                    state_nxt = ACS;
                end
            end
            // a single ACS cycle, traceback only once the window is full
            ACS: begin
                state_nxt = step.filled ? TRACE : IDLE;
            end
            TRACE: begin
                if (step.trace_last) begin
                    state_nxt = OUTPUT;
                end
            end
            OUTPUT: begin
                if (out_ready) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // handshake sides
    assign in_ready  = (state == IDLE);
    assign out_valid = (state == OUTPUT);

    // datapath strobes
    assign acs_en           = (state == ACS);
    assign step.fill_inc    = (state == ACS);
    assign step.trace_start = (state == ACS) && step.filled;
    assign step.trace_step  = (state == TRACE);

endmodule

// ==== hdl/vit_counter.sv ====
`timescale 1ns/1ps

`include "vit_config.svh"

module vit_counter import vit_ctrl_pkg::*; (
    input logic   clk,
    input logic   reset,
    step_if.count step
);

    fill_cnt_t fill_cnt;
    step_cnt_t step_cnt;

    ////////////////////////////////////////////////////////////////////////
    // fill count
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            fill_cnt <= '0;
        end else if (step.fill_inc && (fill_cnt != fill_cnt_t'(`VIT_TB_DEPTH))) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // the symbol now in ACS completes a full window of stored words
    assign step.filled = (fill_cnt >= fill_cnt_t'(`VIT_TB_DEPTH - 1));

    ////////////////////////////////////////////////////////////////////////
    // traceback steps
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            step_cnt <= '0;
        end else if (step.trace_start) begin
            // first TRACE cycle is step 1
            step_cnt <= step_cnt_t'(1);
        end else if (step.trace_step) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    assign step.trace_last = (step_cnt == step_cnt_t'(`VIT_TB_DEPTH));

endmodule

// ==== hdl/vit_ctrl_pkg.sv ====
package vit_ctrl_pkg;

    // decoder sequence, one symbol in flight at a time
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACS    = 2'd1,
        TRACE  = 2'd2,
        OUTPUT = 2'd3
    } ctrl_state_t;

    // traceback step number, 1 up to the traceback depth
    typedef logic [4:0] step_cnt_t;

    // symbols stored so far, saturating at the traceback depth
    typedef logic [4:0] fill_cnt_t;

endpackage

// ==== hdl/vit_ifs.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////
// survivor memory port
////////////////////////////////////////////////////////////////////////

interface surv_if import vit_trellis_pkg::*; ();

    logic      wr_en;
    decision_t wr_data;
    surv_ptr_t wr_ptr;
    surv_ptr_t rd_addr;
    decision_t rd_data;

    // the ACS array writes one decision word per symbol
    modport writer (output wr_en, output wr_data);

    modport mem (input wr_en, input wr_data, input rd_addr, output wr_ptr, output rd_data);

    // traceback reads asynchronously at rd_addr
    modport reader (output rd_addr, input wr_ptr, input rd_data);

endinterface

////////////////////////////////////////////////////////////////////////
// control to counter strobes
////////////////////////////////////////////////////////////////////////

interface step_if ();

    logic fill_inc;
    logic trace_start;
    logic trace_step;
    logic filled;
    logic trace_last;

    modport ctrl (output fill_inc, output trace_start, output trace_step,
                  input filled, input trace_last);

    modport count (input fill_inc, input trace_start, input trace_step,
                   output filled, output trace_last);

endinterface

// ==== hdl/vit_trellis_pkg.sv ====
`include "vit_config.svh"

package vit_trellis_pkg;

    // received code symbol, bit 0 from G0 and bit 1 from G1
    typedef logic [1:0] symbol_t;

    // encoder state, the last four input bits
    // newest bit sits in bit 0
    typedef logic [`VIT_K-2:0] state_t;

    // accumulated path metric
    typedef logic [`VIT_METRIC_W-1:0] metric_t;

    // hamming distance of one symbol, 0 to 2
    typedef logic [1:0] bmetric_t;

    // one bit per state, set when the upper predecessor survived
    typedef logic [`VIT_NUM_STATES-1:0] decision_t;

    // survivor memory address
    typedef logic [`VIT_PTR_W-1:0] surv_ptr_t;

endpackage

// ==== hdl/viterbi_top.sv ====
`timescale 1ns/1ps

module viterbi_top import vit_trellis_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    // symbol input
    input  logic    in_valid,
    output logic    in_ready,
    input  symbol_t in_symbol,
    // decoded bit output
    output logic    out_valid,
    input  logic    out_ready,
    output logic    out_bit
);

    logic   accept;
    logic   acs_en;
    state_t best_state;

    surv_if surv0 ();
    step_if step0 ();

    assign accept = in_valid & in_ready;

    ////////////////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////////////////

    vit_control control0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .acs_en    (acs_en),
        .step      (step0.ctrl)
    );

    vit_counter counter0 (
        .clk   (clk),
        .reset (reset),
        .step  (step0.count)
    );

    ////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////

    acs_array acs0 (
        .clk        (clk),
        .reset      (reset),
        .in_symbol  (in_symbol),
        .accept     (accept),
        .acs_en     (acs_en),
        .surv       (surv0.writer),
        .best_state (best_state)
    );

    survivor_mem mem0 (
        .clk   (clk),
        .reset (reset),
        .surv  (surv0.mem)
    );

    traceback_unit trace0 (
        .clk         (clk),
        .reset       (reset),
        .trace_start (step0.trace_start),
        .trace_step  (step0.trace_step),
        .best_state  (best_state),
        .surv        (surv0.reader),
        .out_bit     (out_bit)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the Viterbi testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f viterbi.f --top-module tb_viterbi \
    -o tb_viterbi > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_viterbi > sim.log 2>&1
cat sim.log

grep -q "SIMULATION PASSED" sim.log && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

// ==== sim/tb_viterbi.sv ====
`timescale 1ns/1ps

`include "vit_config.svh"

module tb_viterbi import vit_trellis_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;

    // test lengths in symbols
    localparam int ZERO_BITS   = 40;
    localparam int RANDOM_BITS = 300;
    localparam int ERROR_BITS  = 300;
    localparam int BP_BITS     = 200;
    localparam int GAP_BITS    = 200;

    localparam int TOTAL_SYMBOLS   = ZERO_BITS + RANDOM_BITS + ERROR_BITS + BP_BITS + GAP_BITS;
    localparam int WATCHDOG_CYCLES = 50 * TOTAL_SYMBOLS + 1000;

    // symbols that never produce an output at the end of a stream
    localparam int HELD_BACK = `VIT_TB_DEPTH - 1;

    logic    clk;
    logic    reset;
    logic    in_valid;
    logic    in_ready;
    symbol_t in_symbol;
    logic    out_valid;
    logic    out_ready;
    logic    out_bit;

    integer seed;
    logic   exp_q[$];
    logic   exp_bit;
    int     acc_count;
    int     out_count;
    logic   bp_en;

    viterbi_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_symbol (in_symbol),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bit   (out_bit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////
    // reference encoder and checking helpers
    ////////////////////////////////////////////////////////////////////////

    // code symbol for one input bit, window is {state, new bit}
    function automatic symbol_t encode_bit(input state_t state, input logic in_bit);
        logic [`VIT_K-1:0] window;
        window = {state, in_bit};
        encode_bit[0] = ^(window & `VIT_G0);
        encode_bit[1] = ^(window & `VIT_G1);
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t ns",
                     name, got, expected, $time);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////

    // one clock edge, with out_ready redrawn when back-pressure is on
    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge clk);
        rnd = $random(seed);
        out_ready <= bp_en ? (rnd[1:0] != 2'd0) : 1'b1;
    endtask

    task automatic apply_reset();
        next_cycle();
        reset    <= 1'b1;
        in_valid <= 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        exp_q.delete();
        acc_count = 0;
        out_count = 0;
        reset <= 1'b0;
    endtask

    // holds the symbol until the edge that accepts it
    task automatic send_symbol(input symbol_t sym);
        in_valid  <= 1'b1;
        in_symbol <= sym;
        do begin
            next_cycle();
        end while (!in_ready);
    endtask

    task automatic run_test(input string name, input int n_bits, input bit random_data,
                            input bit inject_errors, input bit use_gaps,
                            input bit use_backpressure);
        state_t      enc_state;
        symbol_t     sym;
        logic        data_bit;
        logic [31:0] rnd;
        int          next_err;
        int          gap;
        $display("test %s, %0d symbols", name, n_bits);
        bp_en = use_backpressure;
        apply_reset();
        enc_state = '0;
        next_err  = 8;
        for (int i = 0; i < n_bits; i++) begin
            rnd      = $random(seed);
            data_bit = random_data ? rnd[0] : 1'b0;
            exp_q.push_back(data_bit);
            sym       = encode_bit(enc_state, data_bit);
            enc_state = {enc_state[`VIT_K-3:0], data_bit};
            // single channel error, spaced 12 to 19 symbols apart
            if (inject_errors && (i == next_err)) begin
                sym[rnd[4]] = ~sym[rnd[4]];
                next_err    = i + 12 + int'(rnd[7:5]);
            end
            if (use_gaps) begin
                gap = int'(rnd[9:8]);
                if (gap > 0) begin
                    in_valid <= 1'b0;
                    repeat (gap) next_cycle();
                end
            end
            send_symbol(sym);
        end
        in_valid <= 1'b0;
        // back in IDLE means the last output handshake is done
        do begin
            next_cycle();
        end while (!in_ready);
        check_value("output count", out_count, n_bits - HELD_BACK);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset) begin
            if (in_valid && in_ready) begin
                acc_count++;
            end
            if (out_valid) begin
                // no new symbol while a decoded bit waits
                check_value("in_ready", in_ready, 0);
                if (acc_count < `VIT_TB_DEPTH) begin
                    report_failure("out_valid rose before a full traceback window was accepted");
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("output handshake with no input bit left to match");
                end else begin
                    exp_bit = exp_q.pop_front();
                    check_value("out_bit", out_bit, exp_bit);
                    out_count++;
                end
            end
        end
    end

    // watchdog sized from the total stimulus length
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("timeout, the decoder stopped responding");
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_symbol = '0;
        out_ready = 1'b0;
        bp_en     = 1'b0;
        seed      = 32'hd317_de40;
        acc_count = 0;
        out_count = 0;

        run_test("all-zero input", ZERO_BITS, 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("random data", RANDOM_BITS, 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("isolated errors", ERROR_BITS, 1'b1, 1'b1, 1'b0, 1'b0);
        run_test("output back-pressure", BP_BITS, 1'b1, 1'b0, 1'b0, 1'b1);
        run_test("input gaps", GAP_BITS, 1'b1, 1'b0, 1'b1, 1'b0);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== viterbi.f ====
+incdir+hdl
hdl/vit_trellis_pkg.sv
hdl/vit_ctrl_pkg.sv
hdl/vit_ifs.sv
hdl/vit_control.sv
hdl/vit_counter.sv
hdl/acs_array.sv
hdl/survivor_mem.sv
hdl/traceback_unit.sv
hdl/viterbi_top.sv
sim/tb_viterbi.sv
